/* hw/rv_pkg.sv */
// rv64i core shared types
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [1:0]  mem_size_t;
  typedef logic [1:0]  mem_resp_t;

  localparam mem_size_t SIZE_DWORD = 2'b11;

  // major opcodes
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  // funct3 values of the kept operations
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_LD  = 3'b011;
  localparam logic [2:0] F3_SD  = 3'b011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    xlen_t pc;
    inst_t inst;
  } if_to_id_t;

  typedef struct packed {
    xlen_t     pc;
    inst_t     inst;
    reg_addr_t rs1;
    xlen_t     rs1_val;
    reg_addr_t rs2;
    xlen_t     rs2_val;
    xlen_t     imm;
    alu_op_e   alu_op;
    logic      use_imm;
    reg_addr_t rd;
    logic      rd_wen;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      branch_ne;
    logic      is_jal;
  } id_to_ex_t;

  typedef struct packed {
    xlen_t     pc;
    inst_t     inst;
    xlen_t     result;
    xlen_t     store_data;
    reg_addr_t rd;
    logic      rd_wen;
    logic      is_load;
    logic      is_store;
  } ex_to_mem_t;

  typedef struct packed {
    xlen_t     pc;
    inst_t     inst;
    reg_addr_t rd;
    logic      rd_wen;
    xlen_t     result;
  } mem_to_wb_t;

  // pending means the producer is a load still waiting for data
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xlen_t     data;
    logic      pending;
  } forward_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } bj_ctrl_t;

  typedef struct packed {
    xlen_t     pc;
    inst_t     inst;
    logic      wen;
    reg_addr_t rd;
    xlen_t     wdata;
  } commit_t;

endpackage

/* hw/regfile.sv */
// general purpose register file
`timescale 1ns/10ps

module regfile import rv_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t r_addr1,
  input  reg_addr_t r_addr2,
  input  logic      w_ena,
  input  reg_addr_t w_addr,
  input  xlen_t     w_data,
  output xlen_t     r_data1,
  output xlen_t     r_data2
);

  // x0 is not stored
  xlen_t regs [1:31];

  // a write in the same cycle is seen by the read
  function automatic xlen_t read_port(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (w_ena && w_addr == addr) begin
      return w_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    r_data1 = read_port(r_addr1);
    r_data2 = read_port(r_addr2);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (w_ena && w_addr != '0) begin
      regs[w_addr] <= w_data;
    end
  end

endmodule

/* hw/if_stage.sv */
// instruction fetch stage
`timescale 1ns/10ps

module if_stage import rv_pkg::*; #(
  parameter xlen_t PC_START = 64'h0000_0000_8000_0000
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      id_allowin,
  input  bj_ctrl_t  bj_ctrl,
  input  logic      if_rw_ready,
  input  xlen_t     if_r_data,
  input  mem_resp_t if_rw_resp,
  output logic      if_to_id_valid,
  output if_to_id_t if_to_id_bus,
  output logic      if_rw_valid,
  output xlen_t     if_rw_addr,
  output mem_size_t if_rw_size
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_HOLD
  } fetch_state_e;

  fetch_state_e state;
  // pc is the next address to fetch, req_pc the one in flight
  xlen_t pc;
  xlen_t req_pc;
  xlen_t fetch_pc;
  logic  discard;
  logic  start;
  inst_t fetched;

  assign fetch_pc = bj_ctrl.taken ? bj_ctrl.target : pc;
  // a redirect in hold drops the buffered instruction and refetches
  assign start = (state == S_IDLE) || (state == S_HOLD && (id_allowin || bj_ctrl.taken));

  // bad response turns into an unknown opcode, decoded as a no-op
  assign fetched = (if_rw_resp != '0) ? '0 :
                   (req_pc[2] ? if_r_data[63:32] : if_r_data[31:0]);

  assign if_rw_valid    = (state == S_REQ);
  assign if_rw_addr     = {req_pc[63:3], 3'b000};
  assign if_rw_size     = SIZE_DWORD;
  assign if_to_id_valid = (state == S_HOLD);

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= S_IDLE;
      pc      <= PC_START;
      discard <= 1'b0;
    end else if (start) begin
      state <= S_REQ;
      pc    <= fetch_pc + 64'd4;
    end else if (state == S_REQ) begin
      if (bj_ctrl.taken) begin
        pc <= bj_ctrl.target;
      end
      if (if_rw_ready) begin
        state   <= (discard || bj_ctrl.taken) ? S_IDLE : S_HOLD;
        discard <= 1'b0;
      end else if (bj_ctrl.taken) begin
        discard <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      req_pc <= fetch_pc;
    end
    if (state == S_REQ && if_rw_ready) begin
      if_to_id_bus.pc   <= req_pc;
      if_to_id_bus.inst <= fetched;
    end
  end

endmodule

/* hw/id_stage.sv */
// instruction decode stage
`timescale 1ns/10ps

module id_stage import rv_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      if_to_id_valid,
  input  if_to_id_t if_to_id_bus,
  input  logic      ex_allowin,
  input  bj_ctrl_t  bj_ctrl,
  input  xlen_t     r_data1,
  input  xlen_t     r_data2,
  output logic      id_allowin,
  output logic      id_to_ex_valid,
  output id_to_ex_t id_to_ex_bus,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr
);

  logic       id_valid;
  if_to_id_t  id_reg;
  inst_t      inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f3_ok;
  logic       wen;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  // shared by register and immediate forms
  function automatic alu_op_e f3_to_alu(logic [2:0] f3);
    case (f3)
      F3_SLT:  return ALU_SLT;
      F3_XOR:  return ALU_XOR;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign id_allowin     = !id_valid || ex_allowin;
  // wrong-path item must not reach execute
  assign id_to_ex_valid = id_valid && !bj_ctrl.taken;

  always_ff @(posedge clock) begin
    if (reset || bj_ctrl.taken) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_to_id_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (if_to_id_valid && id_allowin) begin
      id_reg <= if_to_id_bus;
    end
  end

  assign inst   = id_reg.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign f3_ok  = funct3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND};

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // unused source fields read as x0 so they never stall execute
  assign rs1_addr = (opcode inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH}) ?
                    inst[19:15] : '0;
  assign rs2_addr = (opcode inside {OP_REG, OP_STORE, OP_BRANCH}) ? inst[24:20] : '0;

  always_comb begin
    id_to_ex_bus         = '0;
    wen                  = 1'b0;
    id_to_ex_bus.pc      = id_reg.pc;
    id_to_ex_bus.inst    = inst;
    id_to_ex_bus.rs1     = rs1_addr;
    id_to_ex_bus.rs1_val = r_data1;
    id_to_ex_bus.rs2     = rs2_addr;
    id_to_ex_bus.rs2_val = r_data2;
    id_to_ex_bus.rd      = inst[11:7];
    id_to_ex_bus.alu_op  = ALU_ADD;
    case (opcode)
      OP_REG: begin
        wen = f3_ok && (funct7 == F7_BASE || (funct7 == F7_SUB && funct3 == F3_ADD));
        id_to_ex_bus.alu_op = (funct7 == F7_SUB) ? ALU_SUB : f3_to_alu(funct3);
      end
      OP_IMM: begin
        wen = f3_ok;
        id_to_ex_bus.use_imm = 1'b1;
        id_to_ex_bus.imm     = imm_i;
        id_to_ex_bus.alu_op  = f3_to_alu(funct3);
      end
      OP_LUI: begin
        wen = 1'b1;
        id_to_ex_bus.use_imm = 1'b1;
        id_to_ex_bus.imm     = imm_u;
        id_to_ex_bus.alu_op  = ALU_PASS_B;
      end
      OP_LOAD: begin
        wen = (funct3 == F3_LD);
        id_to_ex_bus.is_load = (funct3 == F3_LD);
        id_to_ex_bus.use_imm = 1'b1;
        id_to_ex_bus.imm     = imm_i;
      end
      OP_STORE: begin
        id_to_ex_bus.is_store = (funct3 == F3_SD);
        id_to_ex_bus.use_imm  = 1'b1;
        id_to_ex_bus.imm      = imm_s;
      end
      OP_BRANCH: begin
        id_to_ex_bus.is_branch = funct3 inside {F3_BEQ, F3_BNE};
        id_to_ex_bus.branch_ne = (funct3 == F3_BNE);
        id_to_ex_bus.imm       = imm_b;
      end
      OP_JAL: begin
        wen = 1'b1;
        id_to_ex_bus.is_jal = 1'b1;
        id_to_ex_bus.imm    = imm_j;
      end
      default: begin
        wen = 1'b0;
      end
    endcase
    // writes to x0 are dropped here
    id_to_ex_bus.rd_wen = wen && (inst[11:7] != '0);
  end

endmodule

/* hw/ex_stage.sv */
// execute stage
`timescale 1ns/10ps

module ex_stage import rv_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       id_to_ex_valid,
  input  id_to_ex_t  id_to_ex_bus,
  input  logic       mem_allowin,
  input  forward_t   mem_forward,
  input  forward_t   wb_forward,
  output logic       ex_allowin,
  output logic       ex_to_mem_valid,
  output ex_to_mem_t ex_to_mem_bus,
  output bj_ctrl_t   bj_ctrl
);

  logic      ex_valid;
  id_to_ex_t ex_reg;
  xlen_t     src1;
  xlen_t     src2;
  xlen_t     op_b;
  xlen_t     alu_out;
  logic      ready_go;
  logic      cond;

  // memory stage is newer than write-back, so it wins
  function automatic xlen_t fwd_value(reg_addr_t idx, xlen_t rf_val,
                                      forward_t mf, forward_t wf);
    if (idx != '0 && mf.valid && mf.rd == idx) begin
      return mf.data;
    end
    if (idx != '0 && wf.valid && wf.rd == idx) begin
      return wf.data;
    end
    return rf_val;
  endfunction

  function automatic logic fwd_pending(reg_addr_t idx, forward_t mf, forward_t wf);
    if (idx == '0) begin
      return 1'b0;
    end
    if (mf.valid && mf.rd == idx) begin
      return mf.pending;
    end
    if (wf.valid && wf.rd == idx) begin
      return wf.pending;
    end
    return 1'b0;
  endfunction

  assign src1     = fwd_value(ex_reg.rs1, ex_reg.rs1_val, mem_forward, wb_forward);
  assign src2     = fwd_value(ex_reg.rs2, ex_reg.rs2_val, mem_forward, wb_forward);
  assign ready_go = !(fwd_pending(ex_reg.rs1, mem_forward, wb_forward) ||
                      fwd_pending(ex_reg.rs2, mem_forward, wb_forward));
  assign op_b     = ex_reg.use_imm ? ex_reg.imm : src2;

  always_comb begin
    case (ex_reg.alu_op)
      ALU_ADD:    alu_out = src1 + op_b;
      ALU_SUB:    alu_out = src1 - op_b;
      ALU_AND:    alu_out = src1 & op_b;
      ALU_OR:     alu_out = src1 | op_b;
      ALU_XOR:    alu_out = src1 ^ op_b;
      ALU_SLT:    alu_out = {63'b0, $signed(src1) < $signed(op_b)};
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  // bne is beq with the comparison inverted
  assign cond = ex_reg.is_jal ||
                (ex_reg.is_branch && ((src1 == src2) != ex_reg.branch_ne));

  assign ex_to_mem_valid = ex_valid && ready_go;
  assign ex_allowin      = !ex_valid || (ready_go && mem_allowin);
  assign bj_ctrl.taken   = ex_to_mem_valid && mem_allowin && cond;
  assign bj_ctrl.target  = ex_reg.pc + ex_reg.imm;

  assign ex_to_mem_bus = '{
    pc:         ex_reg.pc,
    inst:       ex_reg.inst,
    result:     ex_reg.is_jal ? ex_reg.pc + 64'd4 : alu_out,
    store_data: src2,
    rd:         ex_reg.rd,
    rd_wen:     ex_reg.rd_wen,
    is_load:    ex_reg.is_load,
    is_store:   ex_reg.is_store
  };

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (id_to_ex_valid && ex_allowin) begin
      ex_reg <= id_to_ex_bus;
    end else begin
      // a held item keeps its operands current as producers retire
      ex_reg.rs1_val <= src1;
      ex_reg.rs2_val <= src2;
    end
  end

endmodule

/* hw/mem_stage.sv */
// memory access stage
`timescale 1ns/10ps

module mem_stage import rv_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       ex_to_mem_valid,
  input  ex_to_mem_t ex_to_mem_bus,
  input  logic       wb_allowin,
  input  logic       mem_rw_ready,
  input  xlen_t      mem_r_data,
  input  mem_resp_t  mem_rw_resp,
  output logic       mem_allowin,
  output logic       mem_to_wb_valid,
  output mem_to_wb_t mem_to_wb_bus,
  output forward_t   mem_forward,
  output logic       mem_rw_valid,
  output logic       mem_rw_req,
  output xlen_t      mem_w_data,
  output xlen_t      mem_rw_addr,
  output mem_size_t  mem_rw_size
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUSY,
    S_DONE
  } mem_state_e;

  mem_state_e state;
  logic       mem_valid;
  ex_to_mem_t mem_reg;
  xlen_t      load_buf;
  xlen_t      rsp_data;
  xlen_t      result;
  logic       is_mem;
  logic       data_ready;
  logic       ready_go;
  logic       mem_leave;

  assign is_mem     = mem_reg.is_load || mem_reg.is_store;
  assign rsp_data   = (mem_rw_resp == '0) ? mem_r_data : '0;
  // data usable in the ready cycle itself, or later from the buffer
  assign data_ready = (state == S_DONE) || (state == S_BUSY && mem_rw_ready);
  assign ready_go   = !is_mem || data_ready;
  assign mem_leave  = mem_valid && ready_go && wb_allowin;

  assign mem_allowin     = !mem_valid || (ready_go && wb_allowin);
  assign mem_to_wb_valid = mem_valid && ready_go;

  assign result = !mem_reg.is_load ? mem_reg.result :
                  (state == S_DONE) ? load_buf : rsp_data;

  assign mem_rw_valid = mem_valid && is_mem && (state != S_DONE);
  assign mem_rw_req   = mem_reg.is_store;
  assign mem_w_data   = mem_reg.store_data;
  assign mem_rw_addr  = mem_reg.result;
  assign mem_rw_size  = SIZE_DWORD;

  assign mem_to_wb_bus = '{
    pc:     mem_reg.pc,
    inst:   mem_reg.inst,
    rd:     mem_reg.rd,
    rd_wen: mem_reg.rd_wen,
    result: result
  };

  assign mem_forward = '{
    valid:   mem_valid && mem_reg.rd_wen,
    rd:      mem_reg.rd,
    data:    result,
    pending: mem_reg.is_load && !data_ready
  };

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid <= 1'b0;
      state     <= S_IDLE;
    end else begin
      if (mem_allowin) begin
        mem_valid <= ex_to_mem_valid;
      end
      case (state)
        S_IDLE:  if (mem_valid && is_mem) state <= S_BUSY;
        S_BUSY:  if (mem_rw_ready) state <= mem_leave ? S_IDLE : S_DONE;
        S_DONE:  if (mem_leave) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ex_to_mem_valid && mem_allowin) begin
      mem_reg <= ex_to_mem_bus;
    end
    if (state == S_BUSY && mem_rw_ready) begin
      load_buf <= rsp_data;
    end
  end

endmodule

/* hw/wb_stage.sv */
// write-back stage
`timescale 1ns/10ps

module wb_stage import rv_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       mem_to_wb_valid,
  input  mem_to_wb_t mem_to_wb_bus,
  output logic       wb_allowin,
  output logic       reg_wr_ena,
  output reg_addr_t  reg_wr_addr,
  output xlen_t      reg_wr_data,
  output forward_t   wb_forward,
  output logic       commit_valid,
  output commit_t    commit
);

  logic       wb_valid;
  mem_to_wb_t wb_reg;

  // last stage, nothing downstream to wait on
  assign wb_allowin = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      wb_valid <= mem_to_wb_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_to_wb_valid && wb_allowin) begin
      wb_reg <= mem_to_wb_bus;
    end
  end

  assign reg_wr_ena  = wb_valid && wb_reg.rd_wen;
  assign reg_wr_addr = wb_reg.rd;
  assign reg_wr_data = wb_reg.result;

  assign wb_forward = '{
    valid:   reg_wr_ena,
    rd:      wb_reg.rd,
    data:    wb_reg.result,
    pending: 1'b0
  };

  assign commit_valid = wb_valid;
  assign commit = '{
    pc:    wb_reg.pc,
    inst:  wb_reg.inst,
    wen:   wb_reg.rd_wen,
    rd:    wb_reg.rd,
    wdata: wb_reg.result
  };

endmodule

/* hw/cpu.sv */
// five-stage rv64i core top
`timescale 1ns/10ps

module cpu import rv_pkg::*; #(
  parameter xlen_t PC_START = 64'h0000_0000_8000_0000
) (
  input  logic      clock,
  input  logic      reset,
  // instruction port
  output logic      if_rw_valid,
  input  logic      if_rw_ready,
  input  xlen_t     if_r_data,
  output xlen_t     if_rw_addr,
  output mem_size_t if_rw_size,
  input  mem_resp_t if_rw_resp,
  // data port
  output logic      mem_rw_valid,
  input  logic      mem_rw_ready,
  output logic      mem_rw_req,
  input  xlen_t     mem_r_data,
  output xlen_t     mem_w_data,
  output xlen_t     mem_rw_addr,
  output mem_size_t mem_rw_size,
  input  mem_resp_t mem_rw_resp,
  // retired instructions
  output logic      commit_valid,
  output commit_t   commit
);

  // stage handshakes
  logic       if_to_id_valid;
  logic       id_to_ex_valid;
  logic       ex_to_mem_valid;
  logic       mem_to_wb_valid;
  logic       id_allowin;
  logic       ex_allowin;
  logic       mem_allowin;
  logic       wb_allowin;
  if_to_id_t  if_to_id_bus;
  id_to_ex_t  id_to_ex_bus;
  ex_to_mem_t ex_to_mem_bus;
  mem_to_wb_t mem_to_wb_bus;

  // redirect and forwarding
  bj_ctrl_t   bj_ctrl;
  forward_t   mem_forward;
  forward_t   wb_forward;

  // register file
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  xlen_t      r_data1;
  xlen_t      r_data2;
  logic       reg_wr_ena;
  reg_addr_t  reg_wr_addr;
  xlen_t      reg_wr_data;

  if_stage #(.PC_START(PC_START)) u_if_stage (.*);
  id_stage u_id_stage (.*);
  ex_stage u_ex_stage (.*);
  mem_stage u_mem_stage (.*);
  wb_stage u_wb_stage (.*);

  regfile u_regfile (
    .clock   (clock),
    .reset   (reset),
    .r_addr1 (rs1_addr),
    .r_addr2 (rs2_addr),
    .w_ena   (reg_wr_ena),
    .w_addr  (reg_wr_addr),
    .w_data  (reg_wr_data),
    .r_data1 (r_data1),
    .r_data2 (r_data2)
  );

endmodule

/* dv/cpu_ref_model.sv */
// program builder and reference model
package cpu_ref_pkg;
  import rv_pkg::*;

  localparam xlen_t PC_BASE    = 64'h0000_0000_8000_0000;
  localparam xlen_t DATA_BASE  = 64'h0000_0000_0001_0000;
  localparam int    PROG_LEN   = 60;
  localparam int    DATA_WORDS = 32;
  // last slot is jal x0, 0
  localparam xlen_t LOOP_PC    = PC_BASE + 4 * (PROG_LEN - 1);

  inst_t prog [PROG_LEN];

  // architectural state
  xlen_t ref_regs [32];
  xlen_t ref_mem [DATA_WORDS];
  xlen_t ref_pc;

  function automatic int pick(inout integer seed, input int n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic xlen_t data_fill(xlen_t addr);
    return addr ^ {addr[31:0], addr[63:32]} ^ 64'hc3a5_5a3c_0f1e_e1f0;
  endfunction

  function automatic logic [2:0] alu_funct3(inout integer seed);
    case (pick(seed, 5))
      0:       return F3_ADD;
      1:       return F3_SLT;
      2:       return F3_XOR;
      3:       return F3_OR;
      default: return F3_AND;
    endcase
  endfunction

  function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, F3_SD, imm[4:0], OP_STORE};
  endfunction

  function automatic inst_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic inst_t enc_j(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  // x31 holds the data area base, x0..x7 form a small pool for dependencies
  function automatic void build_program(inout integer seed);
    int          kind;
    int          skip;
    int          last_st;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    prog[0] = {DATA_BASE[31:12], 5'd31, OP_LUI};
    last_st = 0;
    for (int i = 1; i < PROG_LEN - 1; i++) begin
      rd   = pick(seed, 8);
      rs1  = pick(seed, 8);
      rs2  = pick(seed, 8);
      kind = pick(seed, 16);
      // forward only, never beyond the self-loop
      skip = 2 + pick(seed, 3);
      if (i + skip > PROG_LEN - 1) begin
        skip = PROG_LEN - 1 - i;
      end
      if (kind < 4) begin
        if (pick(seed, 6) == 0) begin
          prog[i] = enc_r(F7_SUB, rs2, rs1, F3_ADD, rd);
        end else begin
          prog[i] = enc_r(F7_BASE, rs2, rs1, alu_funct3(seed), rd);
        end
      end else if (kind < 7) begin
        imm12   = pick(seed, 4096);
        prog[i] = enc_i(imm12, rs1, alu_funct3(seed), rd, OP_IMM);
      end else if (kind == 7) begin
        imm20   = pick(seed, 1 << 20);
        prog[i] = {imm20, rd, OP_LUI};
      end else if (kind < 10) begin
        // half of the loads revisit the last stored slot
        imm12   = (pick(seed, 2) == 0) ? last_st : pick(seed, DATA_WORDS) * 8;
        prog[i] = enc_i(imm12, 5'd31, F3_LD, rd, OP_LOAD);
      end else if (kind < 12) begin
        last_st = pick(seed, DATA_WORDS) * 8;
        imm12   = last_st;
        prog[i] = enc_s(imm12, rs2, 5'd31);
      end else if (kind < 14) begin
        prog[i] = enc_b(skip * 4, rs2, rs1, (pick(seed, 2) == 0) ? F3_BEQ : F3_BNE);
      end else begin
        prog[i] = enc_j(skip * 4, rd);
      end
    end
    prog[PROG_LEN - 1] = enc_j('0, '0);
  endfunction

  function automatic void ref_reset();
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      ref_mem[i] = data_fill(DATA_BASE + 8 * i);
    end
    ref_pc = PC_BASE;
  endfunction

  function automatic xlen_t alu_ref(logic [2:0] f3, xlen_t a, xlen_t b);
    case (f3)
      F3_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      F3_XOR:  return a ^ b;
      F3_OR:   return a | b;
      F3_AND:  return a & b;
      default: return a + b;
    endcase
  endfunction

  function automatic int dword_index(xlen_t addr);
    return int'((addr - DATA_BASE) >> 3);
  endfunction

  // executes the instruction at ref_pc and returns its commit record
  function automatic commit_t ref_step();
    commit_t    c;
    inst_t      in;
    logic [2:0] f3;
    reg_addr_t  rd;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      res;
    xlen_t      next_pc;
    logic       wr;
    in      = prog[int'((ref_pc - PC_BASE) >> 2)];
    f3      = in[14:12];
    rd      = in[11:7];
    a       = ref_regs[in[19:15]];
    b       = ref_regs[in[24:20]];
    imm_i   = {{52{in[31]}}, in[31:20]};
    imm_s   = {{52{in[31]}}, in[31:25], in[11:7]};
    res     = '0;
    wr      = 1'b0;
    next_pc = ref_pc + 4;
    case (in[6:0])
      OP_REG: begin
        wr  = 1'b1;
        res = in[30] ? a - b : alu_ref(f3, a, b);
      end
      OP_IMM: begin
        wr  = 1'b1;
        res = alu_ref(f3, a, imm_i);
      end
      OP_LUI: begin
        wr  = 1'b1;
        res = {{32{in[31]}}, in[31:12], 12'h000};
      end
      OP_LOAD: begin
        wr  = 1'b1;
        res = ref_mem[dword_index(a + imm_i)];
      end
      OP_STORE: begin
        ref_mem[dword_index(a + imm_s)] = b;
      end
      OP_BRANCH: begin
        // funct3 bit 0 inverts the equality test
        if ((a == b) != f3[0]) begin
          next_pc = ref_pc + {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        end
      end
      OP_JAL: begin
        wr      = 1'b1;
        res     = ref_pc + 4;
        next_pc = ref_pc + {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
      end
      default: begin
        wr = 1'b0;
      end
    endcase
    c = '{pc: ref_pc, inst: in, wen: wr && rd != '0, rd: rd, wdata: res};
    if (c.wen) begin
      ref_regs[rd] = res;
    end
    ref_pc = next_pc;
    return c;
  endfunction

endpackage

/* dv/cpu_tb.sv */
// testbench for the five-stage core
`timescale 1ns/10ps

module cpu_tb import rv_pkg::*, cpu_ref_pkg::*; ();

  localparam int SEED = 92026;
  // program length x five stages x five cycles per stage
  localparam int TIMEOUT_CYCLES = PROG_LEN * 5 * 5;

  logic      clock;
  logic      reset;
  logic      if_rw_valid;
  logic      if_rw_ready;
  xlen_t     if_r_data;
  xlen_t     if_rw_addr;
  mem_size_t if_rw_size;
  mem_resp_t if_rw_resp;
  logic      mem_rw_valid;
  logic      mem_rw_ready;
  logic      mem_rw_req;
  xlen_t     mem_r_data;
  xlen_t     mem_w_data;
  xlen_t     mem_rw_addr;
  mem_size_t mem_rw_size;
  mem_resp_t mem_rw_resp;
  logic      commit_valid;
  commit_t   commit;

  integer    seed;
  int        cycles;
  int        commits;
  commit_t   expected;
  xlen_t     dmem [DATA_WORDS];
  logic      if_busy;
  int        if_left;
  logic      mem_busy;
  int        mem_left;

  cpu #(.PC_START(PC_BASE)) UUT (.*);

  always #5 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // packs two instructions per doubleword with zeros past the program
  function automatic xlen_t fetch_word(xlen_t addr);
    xlen_t off;
    inst_t lo;
    inst_t hi;
    off = addr - PC_BASE;
    lo  = '0;
    hi  = '0;
    if (off < 4 * PROG_LEN) begin
      lo = prog[off >> 2];
    end
    if (off + 4 < 4 * PROG_LEN) begin
      hi = prog[(off >> 2) + 1];
    end
    return {hi, lo};
  endfunction

  function automatic logic in_data_area(xlen_t addr);
    return addr >= DATA_BASE && addr < DATA_BASE + 8 * DATA_WORDS && addr[2:0] == 3'b000;
  endfunction

  initial begin
    seed         = SEED;
    clock        = 1'b0;
    reset        = 1'b1;
    if_rw_ready  = 1'b0;
    if_r_data    = '0;
    if_rw_resp   = '0;
    mem_rw_ready = 1'b0;
    mem_r_data   = '0;
    mem_rw_resp  = '0;
    cycles       = 0;
    commits      = 0;
    if_busy      = 1'b0;
    mem_busy     = 1'b0;
    build_program(seed);
    ref_reset();
    for (int i = 0; i < DATA_WORDS; i++) begin
      dmem[i] = data_fill(DATA_BASE + 8 * i);
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
  end

  // ready on both memory ports comes 1 to 4 cycles after the first valid
  always @(posedge clock) begin
    if (reset) begin
      if_rw_ready  <= 1'b0;
      mem_rw_ready <= 1'b0;
      if_busy  = 1'b0;
      mem_busy = 1'b0;
    end else begin
      if (if_rw_ready) begin
        if_rw_ready <= 1'b0;
        if_busy = 1'b0;
      end else if (if_rw_valid) begin
        if (!if_busy) begin
          if_busy = 1'b1;
          if_left = pick(seed, 4);
        end else begin
          if_left = if_left - 1;
        end
        if (if_left == 0) begin
          expect_equal("if_rw_size", if_rw_size, SIZE_DWORD);
          if_rw_ready <= 1'b1;
          if_r_data   <= fetch_word(if_rw_addr);
        end
      end
      if (mem_rw_ready) begin
        mem_rw_ready <= 1'b0;
        mem_busy = 1'b0;
      end else if (mem_rw_valid) begin
        if (!mem_busy) begin
          mem_busy = 1'b1;
          mem_left = pick(seed, 4);
        end else begin
          mem_left = mem_left - 1;
        end
        if (mem_left == 0) begin
          if (!in_data_area(mem_rw_addr)) begin
            abort_run($sformatf("data access at %h lies outside the data area", mem_rw_addr));
          end
          expect_equal("mem_rw_size", mem_rw_size, SIZE_DWORD);
          mem_rw_ready <= 1'b1;
          if (mem_rw_req) begin
            dmem[(mem_rw_addr - DATA_BASE) >> 3] <= mem_w_data;
          end else begin
            mem_r_data <= dmem[(mem_rw_addr - DATA_BASE) >> 3];
          end
        end
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout, self-loop not committed within %0d cycles",
                          TIMEOUT_CYCLES));
    end
  end

  // each commit against the next record of the model
  always @(posedge clock) begin
    if (!reset && commit_valid) begin
      expected = ref_step();
      expect_equal("commit.pc", commit.pc, expected.pc);
      expect_equal("commit.inst", commit.inst, expected.inst);
      expect_equal("commit.wen", commit.wen, expected.wen);
      if (expected.wen) begin
        expect_equal("commit.rd", commit.rd, expected.rd);
        expect_equal("commit.wdata", commit.wdata, expected.wdata);
      end
      commits = commits + 1;
      if (expected.pc == LOOP_PC) begin
        // stored data ends up in the model's memory image
        for (int i = 0; i < DATA_WORDS; i++) begin
          expect_equal($sformatf("dmem[%0d]", i), dmem[i], ref_mem[i]);
        end
        $display("%0d instructions committed in %0d cycles", commits, cycles);
        $display("*** TEST PASSED ***");
        $finish;
      end
    end
  end

endmodule

/* cpu.f */
hw/rv_pkg.sv
hw/regfile.sv
hw/if_stage.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/cpu.sv
dv/cpu_ref_model.sv
dv/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/regfile.sv
      - hw/if_stage.sv
      - hw/id_stage.sv
      - hw/ex_stage.sv
      - hw/mem_stage.sv
      - hw/wb_stage.sv
      - hw/cpu.sv
  - target: test
    files:
      - dv/cpu_ref_model.sv
      - dv/cpu_tb.sv
